/* rtl/truxton_macros.svh */
// memory map and widths of the main CPU bus; region bases are byte addresses
`ifndef TRUXTON_MACROS_SVH
`define TRUXTON_MACROS_SVH

// bus widths
`define TX_DATA_W 16
`define TX_ADDR_W 23

// RAM word address widths
`define TX_WRAM_AW  15
`define TX_PAL_AW   11
`define TX_TVRAM_AW 12
`define TX_LINE_AW  8

// program ROM, 0x000000 - 0x07FFFF
`define TX_ROM_TOP 24'h07FFFF

// regions matched on upper address bits
`define TX_WRAM_BASE   8'h10
`define TX_GCU_BASE    4'h2
`define TX_PAL_BASE    4'h3
`define TX_VCOUNT_BASE 4'h6

// regions matched on a range
`define TX_TVRAM_LO 24'h400000
`define TX_TVRAM_HI 24'h401FFF
`define TX_LSEL_LO  24'h402000
`define TX_LSEL_HI  24'h402FFF
`define TX_LSCR_LO  24'h403000
`define TX_LSCR_HI  24'h4031FF
`define TX_IO_LO    24'h700000
`define TX_IO_HI    24'h700FFF

`endif

/* rtl/truxton_pkg.sv */
// region, I/O port and GCU op encodings; the 4-bit and 3-bit widths are fixed by the top level
package truxton_pkg;

    // one decoded region per CPU access
    typedef enum logic [3:0] {
        REGION_NONE        = 4'd0,
        REGION_ROM         = 4'd1,
        REGION_WORK_RAM    = 4'd2,
        REGION_GCU         = 4'd3,
        REGION_PALETTE     = 4'd4,
        REGION_TEXT_VRAM   = 4'd5,
        REGION_LINE_SELECT = 4'd6,
        REGION_LINE_SCROLL = 4'd7,
        REGION_VCOUNT      = 4'd8,
        REGION_IO          = 4'd9
    } region_e;

    // cabinet ports, byte offset inside the I/O region
    typedef enum logic [2:0] {
        PORT_DSWA   = 3'd0, // 0x0
        PORT_DSWB   = 3'd1, // 0x2
        PORT_JUMPER = 3'd2, // 0x4
        PORT_IN1    = 3'd3, // 0x6
        PORT_IN2    = 3'd4, // 0x8
        PORT_SYS    = 3'd5, // 0xA
        PORT_NONE   = 3'd7
    } io_port_e;

    // GCU operations by offset and direction
    typedef enum logic [2:0] {
        OP_NONE        = 3'd0,
        OP_SET_RAM_PTR = 3'd1, // write 0x0
        OP_WRITE_RAM   = 3'd2, // write 0x4 or 0x6
        OP_SELECT_REG  = 3'd3, // write 0x8
        OP_WRITE_REG   = 3'd4, // write 0xC
        OP_READ_RAM_H  = 3'd5, // read 0x4
        OP_READ_RAM_L  = 3'd6  // read 0x6
    } gcu_op_e;

endpackage

/* rtl/bus_decoder.sv */
// region is valid one clock after AS low and drops to none on the first clock with AS high
`include "truxton_macros.svh"

module bus_decoder (
    input  logic                  CLK96,
    input  logic                  RESET96,
    input  logic [`TX_ADDR_W:1]   cpu_addr,
    input  logic                  cpu_as_n,
    output truxton_pkg::region_e  region,
    output truxton_pkg::io_port_e io_port,
    output logic                  prg_cs,
    output logic [18:0]           prg_addr
);
    logic [`TX_ADDR_W:0]   byte_addr;
    truxton_pkg::region_e  next_region;
    truxton_pkg::io_port_e next_port;

    assign byte_addr = {cpu_addr, 1'b0}; // follows the memory map

    always_comb begin
        next_region = truxton_pkg::REGION_NONE;
        if (!cpu_as_n) begin
            if (byte_addr <= `TX_ROM_TOP)
                next_region = truxton_pkg::REGION_ROM;
            else if (byte_addr[23:16] == `TX_WRAM_BASE)
                next_region = truxton_pkg::REGION_WORK_RAM;
            else if (byte_addr[23:20] == `TX_GCU_BASE)
                next_region = truxton_pkg::REGION_GCU;
            else if (byte_addr[23:20] == `TX_PAL_BASE)
                next_region = truxton_pkg::REGION_PALETTE;
            else if (byte_addr >= `TX_TVRAM_LO && byte_addr <= `TX_TVRAM_HI)
                next_region = truxton_pkg::REGION_TEXT_VRAM;
            else if (byte_addr >= `TX_LSEL_LO && byte_addr <= `TX_LSEL_HI)
                next_region = truxton_pkg::REGION_LINE_SELECT;
            else if (byte_addr >= `TX_LSCR_LO && byte_addr <= `TX_LSCR_HI)
                next_region = truxton_pkg::REGION_LINE_SCROLL;
            else if (byte_addr[23:20] == `TX_VCOUNT_BASE)
                next_region = truxton_pkg::REGION_VCOUNT;
            else if (byte_addr >= `TX_IO_LO && byte_addr <= `TX_IO_HI)
                next_region = truxton_pkg::REGION_IO;
        end
    end

    // port by byte offset, only inside the I/O window
    always_comb begin
        case (byte_addr[11:0])
            12'h000: next_port = truxton_pkg::PORT_DSWA;
            12'h002: next_port = truxton_pkg::PORT_DSWB;
            12'h004: next_port = truxton_pkg::PORT_JUMPER;
            12'h006: next_port = truxton_pkg::PORT_IN1;
            12'h008: next_port = truxton_pkg::PORT_IN2;
            12'h00A: next_port = truxton_pkg::PORT_SYS;
            default: next_port = truxton_pkg::PORT_NONE;
        endcase
        if (next_region != truxton_pkg::REGION_IO)
            next_port = truxton_pkg::PORT_NONE;
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            region  <= truxton_pkg::REGION_NONE;
            io_port <= truxton_pkg::PORT_NONE;
        end else begin
            region  <= next_region;
            io_port <= next_port;
        end
    end

    always_ff @(posedge CLK96) begin
        if (!cpu_as_n)
            prg_addr <= cpu_addr[19:1]; // ROM word address
    end

    assign prg_cs = (region == truxton_pkg::REGION_ROM);

    region_clears_after_as: assert property (
        @(posedge CLK96) disable iff (RESET96)
        $rose(cpu_as_n) |=> region == truxton_pkg::REGION_NONE
    ) else $error("region still selected after cpu_as_n rose");

endmodule

/* rtl/cabinet_inputs.sv */
// joystick, button and DIP inputs are active high here, the CPU sees them active low
`include "truxton_macros.svh"

module cabinet_inputs (
    input  logic                   CLK96,
    input  logic                   RESET96,
    input  truxton_pkg::io_port_e  io_port,
    input  logic [9:0]             joystick1,
    input  logic [9:0]             joystick2,
    input  logic [1:0]             start_button,
    input  logic [1:0]             coin_input,
    input  logic                   service,
    input  logic                   fastscroll,
    input  logic                   p1_socd,
    input  logic                   p2_socd,
    input  logic                   dip_test,
    input  logic [7:0]             dipsw_a,
    input  logic [7:0]             dipsw_b,
    input  logic [7:0]             dipsw_c,
    input  logic                   hsync,
    input  logic                   vsync,
    input  logic                   fblank,
    input  logic [8:0]             vcount,
    output logic [`TX_DATA_W-1:0]  port_data,
    output logic [`TX_DATA_W-1:0]  video_status
);
    logic [7:0] p1_byte;
    logic [7:0] p2_byte;
    logic [7:0] sys_byte;
    logic       p1_right;
    logic       p1_down;
    logic       p2_right;
    logic       p2_down;

    // socd low means opposite directions cancel toward bit 1 / bit 3
    assign p1_right = p1_socd ? joystick1[0] : joystick1[0] & ~joystick1[1];
    assign p1_down  = p1_socd ? joystick1[2] : joystick1[2] & ~joystick1[3];
    assign p2_right = p2_socd ? joystick2[0] : joystick2[0] & ~joystick2[1];
    assign p2_down  = p2_socd ? joystick2[2] : joystick2[2] & ~joystick2[3];

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            p1_byte <= 8'hFF; // nothing pressed
            p2_byte <= 8'h7F;
        end else begin
            p1_byte <= {~(fastscroll | joystick1[7]), ~joystick1[6:3],
                        ~p1_down, ~joystick1[1], ~p1_right};
            p2_byte <= {1'b0, ~joystick2[6:3], ~p2_down, ~joystick2[1], ~p2_right};
        end
    end

    assign sys_byte = {1'b0, ~start_button[1], ~start_button[0], ~coin_input[1],
                       ~coin_input[0], ~dip_test, 1'b0, ~service};

    always_comb begin
        case (io_port)
            truxton_pkg::PORT_DSWA:   port_data = {2{dipsw_a}};
            truxton_pkg::PORT_DSWB:   port_data = {2{dipsw_b}};
            truxton_pkg::PORT_JUMPER: port_data = {2{dipsw_c}};
            truxton_pkg::PORT_IN1:    port_data = {2{p1_byte}};
            truxton_pkg::PORT_IN2:    port_data = {2{p2_byte}};
            truxton_pkg::PORT_SYS:    port_data = {dipsw_c, sys_byte};
            default:                  port_data = '0;
        endcase
    end

    // sync bits sit in an otherwise all-ones high byte
    assign video_status = {hsync, vsync, 5'h1F, fblank,
                           vcount[8] ? 8'hFF : vcount[7:0]}; // lines past 255 read 0xFF

endmodule

/* rtl/gcu_command.sv */
// strobes hold until gcu_ack is seen outside a GCU access; no ack means they hold forever
module gcu_command (
    input  logic                 CLK96,
    input  logic                 RESET96,
    input  truxton_pkg::region_e region,
    input  logic [3:1]           cpu_addr,
    input  logic                 cpu_rw,
    input  logic                 gcu_ack,
    output logic                 op_select_reg,
    output logic                 op_write_reg,
    output logic                 op_write_ram,
    output logic                 op_read_ram_h,
    output logic                 op_read_ram_l,
    output logic                 op_set_ram_ptr
);
    truxton_pkg::gcu_op_e op;
    logic                 gcu_sel;
    logic [5:0]           strobes;

    assign gcu_sel = (region == truxton_pkg::REGION_GCU);

    always_comb begin
        op = truxton_pkg::OP_NONE;
        if (gcu_sel && cpu_rw) begin
            case (cpu_addr)
                3'b010:  op = truxton_pkg::OP_READ_RAM_H; // 0x4
                3'b011:  op = truxton_pkg::OP_READ_RAM_L; // 0x6
                default: op = truxton_pkg::OP_NONE;
            endcase
        end else if (gcu_sel) begin
            case (cpu_addr)
                3'b000:         op = truxton_pkg::OP_SET_RAM_PTR;
                3'b010, 3'b011: op = truxton_pkg::OP_WRITE_RAM;
                3'b100:         op = truxton_pkg::OP_SELECT_REG;
                3'b110:         op = truxton_pkg::OP_WRITE_REG;
                default:        op = truxton_pkg::OP_NONE;
            endcase
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            {op_select_reg, op_write_reg, op_write_ram} <= 3'b000;
            {op_read_ram_h, op_read_ram_l, op_set_ram_ptr} <= 3'b000;
        end else if (gcu_sel) begin
            case (op)
                truxton_pkg::OP_SELECT_REG:  op_select_reg  <= 1'b1;
                truxton_pkg::OP_WRITE_REG:   op_write_reg   <= 1'b1;
                truxton_pkg::OP_WRITE_RAM:   op_write_ram   <= 1'b1;
                truxton_pkg::OP_READ_RAM_H:  op_read_ram_h  <= 1'b1;
                truxton_pkg::OP_READ_RAM_L:  op_read_ram_l  <= 1'b1;
                truxton_pkg::OP_SET_RAM_PTR: op_set_ram_ptr <= 1'b1;
                default: ;
            endcase
        end else if (gcu_ack) begin
            {op_select_reg, op_write_reg, op_write_ram} <= 3'b000;
            {op_read_ram_h, op_read_ram_l, op_set_ram_ptr} <= 3'b000;
        end
    end

    assign strobes = {op_select_reg, op_write_reg, op_write_ram,
                      op_read_ram_h, op_read_ram_l, op_set_ram_ptr};

    no_strobe_without_access: assert property (
        @(posedge CLK96) disable iff (RESET96)
        (strobes & ~$past(strobes)) != 6'b0 |-> $past(gcu_sel)
    ) else $error("GCU strobe rose without a GCU access");

endmodule

/* rtl/shared_ram.sv */
// both ports read one clock after the address; a CPU write returns the old word that cycle
`include "truxton_macros.svh"

module shared_ram #(
    parameter int aw = 8
) (
    input  logic                  CLK96,
    input  logic [aw-1:0]         cpu_addr,
    input  logic [`TX_DATA_W-1:0] cpu_data,
    input  logic [1:0]            cpu_we,     // {upper, lower} byte
    input  logic [aw-1:0]         video_addr,
    output logic [`TX_DATA_W-1:0] cpu_q,
    output logic [`TX_DATA_W-1:0] video_q
);
    logic [`TX_DATA_W-1:0] mem [2**aw];

    always_ff @(posedge CLK96) begin
        if (cpu_we[1])
            mem[cpu_addr][15:8] <= cpu_data[15:8];
        if (cpu_we[0])
            mem[cpu_addr][7:0] <= cpu_data[7:0];
        cpu_q <= mem[cpu_addr];
    end

    // video side never writes
    always_ff @(posedge CLK96) begin
        video_q <= mem[video_addr];
    end

endmodule

/* rtl/cpu_bus_top.sv */
// no DTACK here; the CPU side must wait two clocks after AS low before it takes cpu_din
`include "truxton_macros.svh"

module cpu_bus_top (
    input  logic                    CLK96,
    input  logic                    RESET96,
    input  logic [`TX_ADDR_W:1]     cpu_addr,
    input  logic                    cpu_as_n,
    input  logic                    cpu_uds_n,
    input  logic                    cpu_lds_n,
    input  logic                    cpu_rw,
    input  logic [`TX_DATA_W-1:0]   cpu_dout,
    output logic [`TX_DATA_W-1:0]   cpu_din,
    output logic                    prg_cs,
    output logic [18:0]             prg_addr,
    input  logic [`TX_DATA_W-1:0]   prg_data,
    input  logic                    prg_ok,
    output logic                    op_select_reg,
    output logic                    op_write_reg,
    output logic                    op_write_ram,
    output logic                    op_read_ram_h,
    output logic                    op_read_ram_l,
    output logic                    op_set_ram_ptr,
    input  logic [`TX_DATA_W-1:0]   gcu_dout,
    input  logic                    gcu_ack,
    input  logic                    hsync,
    input  logic                    vsync,
    input  logic                    fblank,
    input  logic [8:0]              vcount,
    input  logic [9:0]              joystick1,
    input  logic [9:0]              joystick2,
    input  logic [1:0]              start_button,
    input  logic [1:0]              coin_input,
    input  logic                    service,
    input  logic                    fastscroll,
    input  logic                    p1_socd,
    input  logic                    p2_socd,
    input  logic                    dip_test,
    input  logic [7:0]              dipsw_a,
    input  logic [7:0]              dipsw_b,
    input  logic [7:0]              dipsw_c,
    input  logic [`TX_PAL_AW-1:0]   pal_video_addr,
    input  logic [`TX_TVRAM_AW-1:0] tvram_video_addr,
    input  logic [`TX_LINE_AW-1:0]  line_select_video_addr,
    input  logic [`TX_LINE_AW-1:0]  line_scroll_video_addr,
    output logic [`TX_DATA_W-1:0]   pal_video_data,
    output logic [`TX_DATA_W-1:0]   tvram_video_data,
    output logic [`TX_DATA_W-1:0]   line_select_video_data,
    output logic [`TX_DATA_W-1:0]   line_scroll_video_data
);
    truxton_pkg::region_e  region;
    truxton_pkg::io_port_e io_port;
    logic [`TX_DATA_W-1:0] port_data;
    logic [`TX_DATA_W-1:0] video_status;
    logic [`TX_DATA_W-1:0] wram_q;
    logic [`TX_DATA_W-1:0] pal_q;
    logic [`TX_DATA_W-1:0] tvram_q;
    logic [`TX_DATA_W-1:0] lsel_q;
    logic [`TX_DATA_W-1:0] lscr_q;
    logic [1:0]            wr_lanes;

    bus_decoder decoder_i (
        .CLK96(CLK96), .RESET96(RESET96), .cpu_addr(cpu_addr), .cpu_as_n(cpu_as_n),
        .region(region), .io_port(io_port), .prg_cs(prg_cs), .prg_addr(prg_addr)
    );

    cabinet_inputs cabinet_i (
        .CLK96(CLK96), .RESET96(RESET96), .io_port(io_port),
        .joystick1(joystick1), .joystick2(joystick2),
        .start_button(start_button), .coin_input(coin_input),
        .service(service), .fastscroll(fastscroll),
        .p1_socd(p1_socd), .p2_socd(p2_socd), .dip_test(dip_test),
        .dipsw_a(dipsw_a), .dipsw_b(dipsw_b), .dipsw_c(dipsw_c),
        .hsync(hsync), .vsync(vsync), .fblank(fblank), .vcount(vcount),
        .port_data(port_data), .video_status(video_status)
    );

    gcu_command gcu_i (
        .CLK96(CLK96), .RESET96(RESET96), .region(region),
        .cpu_addr(cpu_addr[3:1]), .cpu_rw(cpu_rw), .gcu_ack(gcu_ack),
        .op_select_reg(op_select_reg), .op_write_reg(op_write_reg),
        .op_write_ram(op_write_ram), .op_read_ram_h(op_read_ram_h),
        .op_read_ram_l(op_read_ram_l), .op_set_ram_ptr(op_set_ram_ptr)
    );

    // byte lanes to write, still gated by region per RAM
    assign wr_lanes = {~cpu_uds_n, ~cpu_lds_n} & {2{~cpu_rw & ~cpu_as_n}};

    shared_ram #(.aw(`TX_WRAM_AW)) wram_i (
        .CLK96(CLK96), .cpu_addr(cpu_addr[`TX_WRAM_AW:1]), .cpu_data(cpu_dout),
        .cpu_we(region == truxton_pkg::REGION_WORK_RAM ? wr_lanes : 2'b00),
        .video_addr(cpu_addr[`TX_WRAM_AW:1]), // no video reader on work RAM
        .cpu_q(wram_q), .video_q()
    );

    shared_ram #(.aw(`TX_PAL_AW)) pal_i (
        .CLK96(CLK96), .cpu_addr(cpu_addr[`TX_PAL_AW:1]), .cpu_data(cpu_dout),
        .cpu_we(region == truxton_pkg::REGION_PALETTE ? wr_lanes : 2'b00),
        .video_addr(pal_video_addr), .cpu_q(pal_q), .video_q(pal_video_data)
    );

    shared_ram #(.aw(`TX_TVRAM_AW)) tvram_i (
        .CLK96(CLK96), .cpu_addr(cpu_addr[`TX_TVRAM_AW:1]), .cpu_data(cpu_dout),
        .cpu_we(region == truxton_pkg::REGION_TEXT_VRAM ? wr_lanes : 2'b00),
        .video_addr(tvram_video_addr), .cpu_q(tvram_q), .video_q(tvram_video_data)
    );

    // line select window is 4 KB, only the first 0x200 bytes exist and alias
    shared_ram #(.aw(`TX_LINE_AW)) lsel_i (
        .CLK96(CLK96), .cpu_addr(cpu_addr[`TX_LINE_AW:1]), .cpu_data(cpu_dout),
        .cpu_we(region == truxton_pkg::REGION_LINE_SELECT ? wr_lanes : 2'b00),
        .video_addr(line_select_video_addr), .cpu_q(lsel_q),
        .video_q(line_select_video_data)
    );

    shared_ram #(.aw(`TX_LINE_AW)) lscr_i (
        .CLK96(CLK96), .cpu_addr(cpu_addr[`TX_LINE_AW:1]), .cpu_data(cpu_dout),
        .cpu_we(region == truxton_pkg::REGION_LINE_SCROLL ? wr_lanes : 2'b00),
        .video_addr(line_scroll_video_addr), .cpu_q(lscr_q),
        .video_q(line_scroll_video_data)
    );

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            cpu_din <= '0;
        end else if (!cpu_rw) begin
            cpu_din <= '0; // writes read back nothing
        end else begin
            case (region)
                truxton_pkg::REGION_ROM:         cpu_din <= prg_ok ? prg_data : '0;
                truxton_pkg::REGION_WORK_RAM:    cpu_din <= wram_q;
                truxton_pkg::REGION_PALETTE:     cpu_din <= pal_q;
                truxton_pkg::REGION_TEXT_VRAM:   cpu_din <= tvram_q;
                truxton_pkg::REGION_LINE_SELECT: cpu_din <= lsel_q;
                truxton_pkg::REGION_LINE_SCROLL: cpu_din <= lscr_q;
                truxton_pkg::REGION_GCU:
                    cpu_din <= (cpu_addr[3:1] == 3'b110) ? '0 : gcu_dout; // 0xC reads zero
                truxton_pkg::REGION_VCOUNT:      cpu_din <= video_status;
                truxton_pkg::REGION_IO:          cpu_din <= port_data;
                default:                         cpu_din <= '0;
            endcase
        end
    end

endmodule

/* verification/cpu_bus_tb.sv */
// RAMs are read back only at addresses written earlier in the run; ROM answers two clocks after prg_cs
`include "truxton_macros.svh"

module cpu_bus_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RAM_ITERS = 40;
    localparam int IO_ITERS  = 8;
    localparam int GCU_CASES = 8;
    // five clocks per bus access, plus the video reads and the ack phases
    localparam int PLANNED = 10 + RAM_ITERS * 18 + IO_ITERS * 36 + 40 + GCU_CASES * 12;
    localparam int TIMEOUT = 2 * PLANNED;
    localparam logic [23:0] RAM_BASE [5] = '{24'h100000, 24'h300000, 24'h400000,
                                             24'h402000, 24'h403000};
    localparam int RAM_AW [5] = '{`TX_WRAM_AW, `TX_PAL_AW, `TX_TVRAM_AW,
                                  `TX_LINE_AW, `TX_LINE_AW};

    logic                    CLK96 = 1'b0;
    logic                    RESET96;
    logic [`TX_ADDR_W:1]     cpu_addr;
    logic                    cpu_as_n, cpu_uds_n, cpu_lds_n, cpu_rw;
    logic [`TX_DATA_W-1:0]   cpu_dout, cpu_din, prg_data, gcu_dout;
    logic                    prg_cs, gcu_ack;
    logic                    prg_ok = 1'b0;
    logic                    rom_busy = 1'b0;
    logic [18:0]             prg_addr;
    logic                    op_select_reg, op_write_reg, op_write_ram;
    logic                    op_read_ram_h, op_read_ram_l, op_set_ram_ptr;
    logic                    hsync, vsync, fblank, service, fastscroll;
    logic                    p1_socd, p2_socd, dip_test;
    logic [8:0]              vcount;
    logic [9:0]              joystick1, joystick2;
    logic [1:0]              start_button, coin_input;
    logic [7:0]              dipsw_a, dipsw_b, dipsw_c;
    logic [`TX_PAL_AW-1:0]   pal_video_addr;
    logic [`TX_TVRAM_AW-1:0] tvram_video_addr;
    logic [`TX_LINE_AW-1:0]  line_select_video_addr, line_scroll_video_addr;
    logic [`TX_DATA_W-1:0]   pal_video_data, tvram_video_data;
    logic [`TX_DATA_W-1:0]   line_select_video_data, line_scroll_video_data;

    logic        check_din = 1'b0;
    logic        check_video = 1'b0;
    logic        check_strobe = 1'b0;
    logic [15:0] exp_din, exp_video, video_data;
    logic [5:0]  exp_strobes, strobes;
    logic        exp_prg_cs;
    logic [18:0] exp_prg_addr;
    int          video_sel = 0;
    int          errors = 0;
    int          cycles = 0;
    logic [15:0] ram_model [int]; // ram index * 65536 + word

    cpu_bus_top dut_i (.*);

    always #5 CLK96 = ~CLK96;

    // ROM model with data valid two clocks after select
    always @(posedge CLK96) begin
        #1;
        prg_ok = rom_busy;
        rom_busy = prg_cs;
    end

    always @(posedge CLK96) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    assign strobes = {op_select_reg, op_write_reg, op_write_ram,
                      op_read_ram_h, op_read_ram_l, op_set_ram_ptr};

    always_comb begin
        case (video_sel)
            1: video_data = pal_video_data;
            2: video_data = tvram_video_data;
            3: video_data = line_select_video_data;
            default: video_data = line_scroll_video_data;
        endcase
    end

    din_matches: assert property (@(posedge CLK96) disable iff (RESET96)
        check_din |-> cpu_din == exp_din)
    else begin
        errors++;
        $display("[FAIL] cpu_din %h expected %h", $sampled(cpu_din), $sampled(exp_din));
    end

    prg_matches: assert property (@(posedge CLK96) disable iff (RESET96)
        check_din |-> prg_cs == exp_prg_cs && (!exp_prg_cs || prg_addr == exp_prg_addr))
    else begin
        errors++;
        $display("[FAIL] prg_cs %h expected %h, prg_addr %h expected %h", $sampled(prg_cs),
                 $sampled(exp_prg_cs), $sampled(prg_addr), $sampled(exp_prg_addr));
    end

    strobes_match: assert property (@(posedge CLK96) disable iff (RESET96)
        (check_din || check_strobe) |-> strobes == exp_strobes)
    else begin
        errors++;
        $display("[FAIL] gcu strobes %h expected %h", $sampled(strobes), $sampled(exp_strobes));
    end

    video_matches: assert property (@(posedge CLK96) disable iff (RESET96)
        check_video |-> video_data == exp_video)
    else begin
        errors++;
        $display("[FAIL] video_q of ram %0d is %h expected %h", video_sel,
                 $sampled(video_data), $sampled(exp_video));
    end

    // second and later clocks of a write
    write_keeps_din_zero: assert property (@(posedge CLK96) disable iff (RESET96)
        (!cpu_as_n && !cpu_rw && $past(!cpu_as_n && !cpu_rw)) |-> cpu_din == '0)
    else begin
        errors++;
        $display("[FAIL] cpu_din %h during a write, expected 0000", $sampled(cpu_din));
    end

    task automatic tick();
        @(posedge CLK96);
        #1;
    endtask

    // one CPU access with AS low for four clocks and cpu_din checked on the last one
    task automatic bus_access(input logic [23:0] byte_addr, input logic rw,
                              input logic [1:0] lanes_n, input logic [15:0] wdata,
                              input logic [15:0] expect_din);
        cpu_addr = byte_addr[23:1];
        cpu_rw = rw;
        {cpu_uds_n, cpu_lds_n} = lanes_n;
        cpu_dout = wdata;
        cpu_as_n = 1'b0;
        exp_din = expect_din;
        exp_prg_cs = byte_addr <= `TX_ROM_TOP;
        exp_prg_addr = byte_addr[19:1];
        repeat (3) tick();
        check_din = 1'b1;
        tick();
        check_din = 1'b0;
        cpu_as_n = 1'b1;
        {cpu_uds_n, cpu_lds_n} = 2'b11;
        tick(); // address and R/W stay valid one clock past AS as on a 68000 bus
        cpu_rw = 1'b1;
    endtask

    task automatic video_read(input int ram, input int word, input logic [15:0] expect_q);
        video_sel = ram;
        case (ram)
            1: pal_video_addr = word[10:0];
            2: tvram_video_addr = word[11:0];
            3: line_select_video_addr = word[7:0];
            default: line_scroll_video_addr = word[7:0];
        endcase
        exp_video = expect_q;
        tick();
        check_video = 1'b1;
        tick();
        check_video = 1'b0;
    endtask

    task automatic ram_test();
        int          ram;
        int          word;
        int          key;
        logic [23:0] addr;
        logic [15:0] data;
        logic [15:0] merged;
        logic [1:0]  lane_n;
        for (int i = 0; i < RAM_ITERS; i++) begin
            ram = i % 5;
            word = $urandom_range((1 << RAM_AW[ram]) - 1);
            key = ram * 65536 + word;
            addr = RAM_BASE[ram] + 24'(word * 2);
            data = 16'($urandom);
            ram_model[key] = data;
            bus_access(addr, 1'b0, 2'b00, data, 16'h0000);
            lane_n = $urandom_range(1) ? 2'b01 : 2'b10; // one byte only
            data = 16'($urandom);
            merged = ram_model[key];
            if (!lane_n[1])
                merged[15:8] = data[15:8];
            if (!lane_n[0])
                merged[7:0] = data[7:0];
            ram_model[key] = merged;
            bus_access(addr, 1'b0, lane_n, data, 16'h0000);
            bus_access(addr, 1'b1, 2'b00, 16'h0000, ram_model[key]);
            if (ram > 0)
                video_read(ram, word, ram_model[key]); // work RAM has no video side
        end
    endtask

    // active-low player byte from the joystick rules
    function automatic logic [7:0] player_byte(input logic [9:0] joy, input logic socd,
                                               input logic p1, input logic fast);
        logic [7:0] pressed;
        logic [7:0] result;
        pressed = joy[7:0];
        if (!socd && joy[1])
            pressed[0] = 1'b0;
        if (!socd && joy[3])
            pressed[2] = 1'b0;
        result = ~pressed;
        result[7] = p1 ? ~(joy[7] | fast) : 1'b0;
        return result;
    endfunction

    task automatic io_test();
        logic [15:0] sys_word;
        logic [15:0] status;
        for (int i = 0; i < IO_ITERS; i++) begin
            joystick1 = 10'($urandom);
            joystick2 = 10'($urandom);
            if (i[2]) begin
                joystick1[3:0] = 4'hF; // opposite directions held
                joystick2[3:0] = 4'hF;
            end
            p1_socd = i[0];
            p2_socd = i[1];
            {start_button, coin_input} = 4'($urandom);
            {service, fastscroll, dip_test, hsync, vsync, fblank} = 6'($urandom);
            {dipsw_a, dipsw_b, dipsw_c} = 24'($urandom);
            vcount = 9'($urandom);
            sys_word = {dipsw_c, 1'b0, ~start_button[1], ~start_button[0], ~coin_input[1],
                        ~coin_input[0], ~dip_test, 1'b0, ~service};
            status = 16'hFFFF;
            status[15] = hsync;
            status[14] = vsync;
            status[8] = fblank;
            status[7:0] = (vcount < 9'd256) ? vcount[7:0] : 8'hFF;
            bus_access(24'h700000, 1'b1, 2'b00, 16'h0000, {2{dipsw_a}});
            bus_access(24'h700002, 1'b1, 2'b00, 16'h0000, {2{dipsw_b}});
            bus_access(24'h700004, 1'b1, 2'b00, 16'h0000, {2{dipsw_c}});
            bus_access(24'h700006, 1'b1, 2'b00, 16'h0000,
                       {2{player_byte(joystick1, p1_socd, 1'b1, fastscroll)}});
            bus_access(24'h700008, 1'b1, 2'b00, 16'h0000,
                       {2{player_byte(joystick2, p2_socd, 1'b0, fastscroll)}});
            bus_access(24'h70000A, 1'b1, 2'b00, 16'h0000, sys_word);
            bus_access(24'h600000, 1'b1, 2'b00, 16'h0000, status);
        end
    endtask

    task automatic rom_test();
        logic [23:0] addr;
        for (int i = 0; i < 4; i++) begin
            addr = {5'd0, 18'($urandom), 1'b0};
            prg_data = 16'($urandom);
            bus_access(addr, 1'b1, 2'b00, 16'h0000, prg_data);
            addr = 24'h080000 | {5'd0, 18'($urandom), 1'b0}; // gap between ROM and work RAM
            bus_access(addr, 1'b1, 2'b00, 16'h0000, 16'h0000);
        end
    endtask

    function automatic logic [5:0] strobe_for(input truxton_pkg::gcu_op_e op);
        case (op)
            truxton_pkg::OP_SELECT_REG:  return 6'b100000;
            truxton_pkg::OP_WRITE_REG:   return 6'b010000;
            truxton_pkg::OP_WRITE_RAM:   return 6'b001000;
            truxton_pkg::OP_READ_RAM_H:  return 6'b000100;
            truxton_pkg::OP_READ_RAM_L:  return 6'b000010;
            truxton_pkg::OP_SET_RAM_PTR: return 6'b000001;
            default:                     return 6'b000000;
        endcase
    endfunction

    // strobe must hold with gcu_ack low, then clear one clock after ack
    task automatic gcu_case(input logic [3:0] offset, input logic rw,
                            input truxton_pkg::gcu_op_e op);
        logic [15:0] rdata;
        exp_strobes = strobe_for(op);
        gcu_dout = 16'($urandom);
        rdata = (rw && offset != 4'hC) ? gcu_dout : 16'h0000;
        bus_access({20'h20000, offset}, rw, 2'b00, 16'($urandom), rdata);
        check_strobe = 1'b1;
        repeat (4) tick();
        gcu_ack = 1'b1;
        tick();
        exp_strobes = 6'b000000;
        repeat (2) tick();
        gcu_ack = 1'b0;
        check_strobe = 1'b0;
    endtask

    initial begin
        void'($urandom(32'hd3a5));
        RESET96 = 1'b1;
        {cpu_as_n, cpu_uds_n, cpu_lds_n, cpu_rw} = 4'hF;
        cpu_addr = '0;
        {cpu_dout, prg_data, gcu_dout} = '0;
        gcu_ack = 1'b0;
        {hsync, vsync, fblank, service, fastscroll, dip_test} = '0;
        {p1_socd, p2_socd} = 2'b11;
        {vcount, joystick1, joystick2, start_button, coin_input} = '0;
        {dipsw_a, dipsw_b, dipsw_c} = '0;
        {pal_video_addr, tvram_video_addr} = '0;
        {line_select_video_addr, line_scroll_video_addr} = '0;
        {exp_din, exp_video, exp_strobes, exp_prg_cs, exp_prg_addr} = '0;
        repeat (8) @(posedge CLK96);
        #1 RESET96 = 1'b0;
        check_din = 1'b1; // idle bus right after reset
        repeat (2) tick();
        check_din = 1'b0;
        ram_test();
        io_test();
        rom_test();
        gcu_case(4'h0, 1'b0, truxton_pkg::OP_SET_RAM_PTR);
        gcu_case(4'h4, 1'b0, truxton_pkg::OP_WRITE_RAM);
        gcu_case(4'h6, 1'b0, truxton_pkg::OP_WRITE_RAM);
        gcu_case(4'h8, 1'b0, truxton_pkg::OP_SELECT_REG);
        gcu_case(4'hC, 1'b0, truxton_pkg::OP_WRITE_REG);
        gcu_case(4'h4, 1'b1, truxton_pkg::OP_READ_RAM_H);
        gcu_case(4'h6, 1'b1, truxton_pkg::OP_READ_RAM_L);
        gcu_case(4'hC, 1'b1, truxton_pkg::OP_NONE);
        tick();
        $display("run complete, %0d errors in %0d cycles", errors, cycles);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* project.f */
+incdir+rtl
rtl/truxton_pkg.sv
rtl/bus_decoder.sv
rtl/cabinet_inputs.sv
rtl/gcu_command.sv
rtl/shared_ram.sv
rtl/cpu_bus_top.sv
verification/cpu_bus_tb.sv

/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert -Wall
TOP        = cpu_bus_tb
FILELIST   = project.f
OBJ_DIR    = obj_dir
PASS_TEXT  = >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# the grep status decides pass or fail
sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F '$(PASS_TEXT)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)
